//--- build.f
bus_pkg.sv
bus_slave_selector.sv
bus_slave_ram.sv
bus_response_mux.sv
bus_top.sv
tb_bus_top.sv

//--- Makefile
# Verilator build and run for the bus interconnect testbench

VERILATOR ?= verilator
TOP       ?= tb_bus_top
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)

check: run
	@if grep -q "SIMULATION PASSED" $(LOG); then \
		echo "check: pass message found in $(LOG)"; \
	else \
		echo "check: pass message missing from $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_bus_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_bus_top import bus_pkg::*; ();

	localparam int SLAVE_COUNT = 8;
	localparam int SLAVE_WORDS = 64;
	localparam int ACK_TIMEOUT = 16;
	localparam int RANDOM_OPS = 200;

	logic      clk_i;
	logic      rst_i;
	logic      master_stb_i;
	logic      master_we_i;
	bus_addr_t master_adr_i;
	bus_data_t master_dat_i;
	bus_data_t master_dat_o;
	logic      master_ack_o;
	logic      adr_err_o;

	// expected words, key is slave index and word index together
	bus_data_t ref_mem [int];
	bus_addr_t written_q [$];

	integer seed = 32'hdb7d_d6e0;
	int     err_data = 0;
	int     err_flag = 0;
	int     err_timeout = 0;

	bus_top #(
		.SLAVE_COUNT (SLAVE_COUNT),
		.SLAVE_WORDS (SLAVE_WORDS)
	) bus_top_inst (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.master_stb_i (master_stb_i),
		.master_we_i  (master_we_i),
		.master_adr_i (master_adr_i),
		.master_dat_i (master_dat_i),
		.master_dat_o (master_dat_o),
		.master_ack_o (master_ack_o),
		.adr_err_o    (adr_err_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	// region from the top nibble, word index is address / 4 mod depth
	function automatic int model_key(input bus_addr_t adr);
		int region;
		int word;
		region = int'(adr[REGION_MSB:REGION_LSB]);
		word = int'((adr >> 2) % SLAVE_WORDS);
		return region * SLAVE_WORDS + word;
	endfunction

	function automatic bus_data_t ref_read(input bus_addr_t adr);
		int key;
		key = model_key(adr);
		if (ref_mem.exists(key)) begin
			return ref_mem[key];
		end
		return '0;
	endfunction

	task automatic store_expected(input bus_addr_t adr, input bus_data_t dat);
		ref_mem[model_key(adr)] = dat;
		written_q.push_back(adr);
	endtask

	task automatic check_data(input bus_data_t got, input bus_data_t exp, input string msg);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
			err_data++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string msg);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s, got %b expected %b", $time, msg, got, exp);
			err_flag++;
		end
	endtask

	// one strobed access, held until ack or until the wait runs out
	task automatic run_access(input logic we, input bus_addr_t adr, input bus_data_t wdat,
			output bus_data_t rdat, output logic ok);
		ok = 1'b0;
		rdat = '0;
		@(posedge clk_i);
		#1;
		master_stb_i = 1'b1;
		master_we_i = we;
		master_adr_i = adr;
		master_dat_i = wdat;
		for (int n = 0; (n < ACK_TIMEOUT) && !ok; n++) begin
			@(negedge clk_i);
			if (master_ack_o) begin
				ok = 1'b1;
				rdat = master_dat_o;
			end
		end
		@(posedge clk_i);
		#1;
		master_stb_i = 1'b0;
		master_we_i = 1'b0;
		if (!ok) begin
			$display("no acknowledge within %0d cycles for access to address %h",
				ACK_TIMEOUT, adr);
			err_timeout++;
		end
	endtask

	task automatic bus_write(input bus_addr_t adr, input bus_data_t dat);
		bus_data_t unused;
		logic      ok;
		run_access(1'b1, adr, dat, unused, ok);
		if (ok) begin
			store_expected(adr, dat);
		end
	endtask

	task automatic bus_read(input bus_addr_t adr, output bus_data_t dat, output logic ok);
		run_access(1'b0, adr, '0, dat, ok);
	endtask

	task automatic read_and_compare(input bus_addr_t adr, input string msg);
		bus_data_t got;
		logic      ok;
		bus_read(adr, got, ok);
		if (ok) begin
			check_data(got, ref_read(adr), msg);
		end
	endtask

	// ack must stay low in the first strobe cycle and rise in the second
	task automatic check_ack_latency(input bus_addr_t adr);
		@(posedge clk_i);
		#1;
		master_stb_i = 1'b1;
		master_we_i = 1'b0;
		master_adr_i = adr;
		@(negedge clk_i);
		check_flag(master_ack_o, 1'b0, "ack in first strobe cycle");
		@(negedge clk_i);
		check_flag(master_ack_o, 1'b1, "ack in second strobe cycle");
		check_data(master_dat_o, ref_read(adr), "read data with ack");
		@(posedge clk_i);
		#1;
		master_stb_i = 1'b0;
	endtask

	task automatic check_unmapped(input bus_addr_t adr);
		@(posedge clk_i);
		#1;
		master_stb_i = 1'b1;
		master_we_i = 1'b0;
		master_adr_i = adr;
		@(negedge clk_i);
		check_flag(adr_err_o, 1'b1, "adr_err on unmapped strobe");
		check_flag(master_ack_o, 1'b0, "ack on unmapped address");
		repeat (3) begin
			@(negedge clk_i);
			check_flag(master_ack_o, 1'b0, "ack on unmapped address");
		end
		@(posedge clk_i);
		#1;
		master_stb_i = 1'b0;
		@(negedge clk_i);
		check_flag(adr_err_o, 1'b0, "adr_err after strobe dropped");
	endtask

	initial begin
		bus_addr_t adr;
		bus_addr_t alias_mask;
		logic [REGION_W-1:0] region;
		int idx;

		rst_i = 1'b1;
		master_stb_i = 1'b0;
		master_we_i = 1'b0;
		// idle address parked in a hole of the map
		master_adr_i = 32'hf000_0000;
		master_dat_i = '0;
		repeat (8) @(posedge clk_i);
		#1;
		rst_i = 1'b0;

		// idle bus after reset
		repeat (4) begin
			@(negedge clk_i);
			check_flag(master_ack_o, 1'b0, "ack while idle");
			check_flag(adr_err_o, 1'b0, "adr_err while idle");
		end

		// same word in every region, read back after all writes
		for (int r = 0; r < SLAVE_COUNT; r++) begin
			adr = {4'(r), 28'h000_000c};
			bus_write(adr, 32'hc0de_0000 + bus_data_t'(r * 32'h0101));
		end
		for (int r = 0; r < SLAVE_COUNT; r++) begin
			adr = {4'(r), 28'h000_000c};
			read_and_compare(adr, "region readback");
		end

		check_ack_latency(32'h2000_000c);

		// same word through a different byte offset and high offset
		bus_write(32'h3000_0014, 32'h5a5a_1234);
		read_and_compare(32'h3abc_0017, "aliased read");

		for (int r = SLAVE_COUNT; r < MAX_SLAVES; r++) begin
			check_unmapped({4'(r), 28'h0000_040});
		end

		// flip only bits that the word index ignores
		alias_mask = 32'h0fff_ffff & ~bus_addr_t'(SLAVE_WORDS * 4 - 4);
		for (int n = 0; n < RANDOM_OPS; n++) begin
			if ((({$random(seed)} % 2) == 0) || (written_q.size() == 0)) begin
				region = 4'({$random(seed)} % SLAVE_COUNT);
				adr = bus_addr_t'($random(seed));
				adr[REGION_MSB:REGION_LSB] = region;
				bus_write(adr, bus_data_t'($random(seed)));
			end else begin
				idx = int'({$random(seed)} % written_q.size());
				adr = written_q[idx] ^ (bus_addr_t'($random(seed)) & alias_mask);
				read_and_compare(adr, "random read");
			end
		end

		repeat (2) @(posedge clk_i);
		$display("errors: data %0d, flag %0d, timeout %0d", err_data, err_flag, err_timeout);
		if ((err_data + err_flag + err_timeout) == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- bus_top.sv
`timescale 1ns/1ns
`default_nettype none

module bus_top import bus_pkg::*; #(
	parameter int SLAVE_COUNT = 8,
	parameter int SLAVE_WORDS = 64
) (
	input  logic      clk_i,
	input  logic      rst_i,
	input  logic      master_stb_i,
	input  logic      master_we_i,
	input  bus_addr_t master_adr_i,
	input  bus_data_t master_dat_i,
	output bus_data_t master_dat_o,
	output logic      master_ack_o,
	output logic      adr_err_o
);

	bus_req_t               req;
	bus_rsp_t               slave_rsp [SLAVE_COUNT];
	bus_rsp_t               master_rsp;
	logic [SLAVE_COUNT-1:0] sel_stb;

	// master request, shared by all slaves
	assign req.we = master_we_i;
	assign req.adr = master_adr_i;
	assign req.dat = master_dat_i;

	bus_slave_selector #(
		.SLAVE_COUNT (SLAVE_COUNT)
	) bus_slave_selector_inst (
		.adr_i     (req.adr),
		.stb_i     (master_stb_i),
		.cs_o      (sel_stb),
		.adr_err_o (adr_err_o)
	);

	// one ram per region, each woken by its own strobe bit
	for (genvar i = 0; i < SLAVE_COUNT; i++) begin : g_slave
		bus_slave_ram #(
			.SLAVE_WORDS (SLAVE_WORDS)
		) bus_slave_ram_inst (
			.clk_i (clk_i),
			.rst_i (rst_i),
			.stb_i (sel_stb[i]),
			.req_i (req),
			.rsp_o (slave_rsp[i])
		);
	end

	// the strobe vector doubles as the response select
	bus_response_mux #(
		.SLAVE_COUNT (SLAVE_COUNT)
	) bus_response_mux_inst (
		.cs_i  (sel_stb),
		.rsp_i (slave_rsp),
		.rsp_o (master_rsp)
	);

	assign master_dat_o = master_rsp.dat;
	assign master_ack_o = master_rsp.ack;

endmodule

`default_nettype wire

//--- bus_response_mux.sv
`timescale 1ns/1ns
`default_nettype none

module bus_response_mux import bus_pkg::*; #(
	parameter int SLAVE_COUNT = 8
) (
	input  logic [SLAVE_COUNT-1:0] cs_i,
	input  bus_rsp_t               rsp_i [SLAVE_COUNT],
	output bus_rsp_t               rsp_o
);

	logic [SLAVE_COUNT-1:0] ack_vec;
	bus_data_t              dat_merge;

	// gather the slave acks into one vector
	always_comb begin
		for (int i = 0; i < SLAVE_COUNT; i++) begin
			ack_vec[i] = rsp_i[i].ack;
		end
	end

	// and-or of the data under the chip selects
	always_comb begin
		dat_merge = '0;
		for (int i = 0; i < SLAVE_COUNT; i++) begin
			dat_merge = dat_merge | ({DATA_W{cs_i[i]}} & rsp_i[i].dat);
		end
	end

	assign rsp_o.dat = dat_merge;
	assign rsp_o.ack = |(ack_vec & cs_i);

	// a slave only acks while the master still points at it
	always_comb begin
		a_no_stray_ack: assert final ((ack_vec & ~cs_i) == '0)
			else $error("unselected slave raised ack");
	end

endmodule

`default_nettype wire

//--- bus_slave_ram.sv
`timescale 1ns/1ns
`default_nettype none

module bus_slave_ram import bus_pkg::*; #(
	parameter int SLAVE_WORDS = 64
) (
	input  logic     clk_i,
	input  logic     rst_i,
	input  logic     stb_i,
	input  bus_req_t req_i,
	output bus_rsp_t rsp_o
);

	localparam int WORD_AW = $clog2(SLAVE_WORDS);

	bus_data_t          mem [SLAVE_WORDS];
	bus_data_t          rd_q;
	slave_state_t       state_q;
	slave_state_t       state_d;
	logic [WORD_AW-1:0] word_idx;
	logic               access;

	// word index needs at least one bit and a power of two depth
	if ((SLAVE_WORDS < 2) || ((SLAVE_WORDS & (SLAVE_WORDS - 1)) != 0)) begin : g_bad_depth
		$error("SLAVE_WORDS must be a power of two, at least 2");
	end

	// higher offset bits are dropped, so the region aliases
	assign word_idx = req_i.adr[WORD_LSB +: WORD_AW];

	// first edge of a strobe while idle
	assign access = stb_i && (state_q == SLV_IDLE);

	always_comb begin
		state_d = state_q;
		case (state_q)
			SLV_IDLE: begin
				if (access) begin
					state_d = SLV_ACK;
				end
			end
			SLV_ACK: begin
				// back to idle even with strobe still high
				state_d = SLV_IDLE;
			end
			default: begin
				state_d = SLV_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= SLV_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// write lands on the access edge, read word held for the ack cycle
	always_ff @(posedge clk_i) begin
		if (access) begin
			if (req_i.we) begin
				mem[word_idx] <= req_i.dat;
				rd_q <= req_i.dat;
			end else begin
				rd_q <= mem[word_idx];
			end
		end
	end

	assign rsp_o.dat = rd_q;
	assign rsp_o.ack = (state_q == SLV_ACK);

	// master keeps strobing this slave until the ack edge
	a_stb_held: assert property (
		@(posedge clk_i) disable iff (rst_i)
		rsp_o.ack |-> stb_i
	) else $error("strobe dropped before the slave ack");

	// request held steady while the access is pending
	a_req_stable: assert property (
		@(posedge clk_i) disable iff (rst_i)
		rsp_o.ack |-> $stable(req_i)
	) else $error("request changed before the slave ack");

endmodule

`default_nettype wire

//--- bus_slave_selector.sv
`timescale 1ns/1ns
`default_nettype none

module bus_slave_selector import bus_pkg::*; #(
	parameter int SLAVE_COUNT = 8
) (
	input  bus_addr_t              adr_i,
	input  logic                   stb_i,
	output logic [SLAVE_COUNT-1:0] cs_o,
	output logic                   adr_err_o
);

	bus_region_t region;
	logic        mapped;

	// the map has room for MAX_SLAVES regions only
	if ((SLAVE_COUNT < 1) || (SLAVE_COUNT > MAX_SLAVES)) begin : g_bad_count
		$error("SLAVE_COUNT must lie between 1 and %0d", MAX_SLAVES);
	end

	assign region = adr_i[REGION_MSB:REGION_LSB];

	// regions at or above the slave count have nothing behind them
	assign mapped = (int'(region) < SLAVE_COUNT);

	// one-hot decode, only while the master strobes
	always_comb begin
		cs_o = '0;
		for (int i = 0; i < SLAVE_COUNT; i++) begin
			cs_o[i] = stb_i && (int'(region) == i);
		end
	end

	// strobe into a hole in the map
	assign adr_err_o = stb_i && !mapped;

endmodule

`default_nettype wire

//--- bus_pkg.sv
`default_nettype none

package bus_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	typedef logic [ADDR_W-1:0] bus_addr_t;
	typedef logic [DATA_W-1:0] bus_data_t;

	// top nibble of the byte address names the slave
	localparam int REGION_MSB = 31;
	localparam int REGION_LSB = 28;
	localparam int REGION_W = REGION_MSB - REGION_LSB + 1;

	// regions the field can name, 16
	localparam int MAX_SLAVES = 1 << REGION_W;

	// byte offset bits below the word index
	localparam int WORD_LSB = 2;

	typedef logic [REGION_W-1:0] bus_region_t;

	// request broadcast to every slave
	typedef struct packed {
		logic      we;
		bus_addr_t adr;
		bus_data_t dat;
	} bus_req_t;

	// response of one slave, or the merged one
	typedef struct packed {
		bus_data_t dat;
		logic      ack;
	} bus_rsp_t;

	typedef enum logic [0:0] {
		SLV_IDLE,
		SLV_ACK
	} slave_state_t;

endpackage

`default_nettype wire
